/* hdl/wro_pkg.sv */
// Shared widths and types; addresses are line addresses and outstanding tags must be unique
package wro_pkg;

    // ==================================================
    // Widths
    // ==================================================

    parameter int ADDR_BITS = 16;
    parameter int TAG_BITS  = 5;
    parameter int DATA_BITS = 32;
    parameter int HASH_BITS = 6;

    // Number of hash-wide chunks needed to cover an address, top chunk padded
    parameter int HASH_CHUNKS = (ADDR_BITS + HASH_BITS - 1) / HASH_BITS;

    typedef logic [ADDR_BITS-1:0] t_addr;
    typedef logic [TAG_BITS-1:0]  t_tag;
    typedef logic [DATA_BITS-1:0] t_data;
    typedef logic [HASH_BITS-1:0] t_hash;

    // ==================================================
    // Channel payloads
    // ==================================================

    typedef struct packed {
        logic  valid;
        t_addr addr;
        t_tag  tag;
        logic  order;
    } t_rd_req;

    typedef struct packed {
        logic  valid;
        t_addr addr;
        t_tag  tag;
        logic  order;
        t_data data;
    } t_wr_req;

    // Same layout serves read and write responses
    typedef struct packed {
        logic valid;
        t_tag tag;
    } t_rsp;

    // What the response side needs to undo a filter insert
    typedef struct packed {
        t_hash hash;
        logic  order;
    } t_heap_entry;

    // Fold the address by XOR of its hash-wide chunks
    function automatic t_hash wro_hash(input t_addr addr);
        logic [HASH_CHUNKS*HASH_BITS-1:0] padded;
        t_hash                            h;
        padded = '0;
        padded[ADDR_BITS-1:0] = addr;
        h = '0;
        for (int i = 0; i < HASH_CHUNKS; i++)
        begin
            h = h ^ padded[i*HASH_BITS +: HASH_BITS];
        end
        return h;
    endfunction

endpackage

/* hdl/wro_req_stage.sv */
// One request in flight per channel; requester must obey full as sampled at each rising edge
`timescale 1ns/10ps

// ==================================================
// Request holding stage, shared by read and write channels
// ==================================================

module wro_req_stage
    import wro_pkg::*;
#(
    // Payload struct, must carry valid and addr fields
    parameter type T = t_rd_req
)
(
    input  logic  clk,
    input  logic  reset,

    // Requester side
    input  T      in_req,
    output logic  full,

    // Order control side
    input  logic  clear,
    output T      head,
    output t_hash head_hash,
    output logic  issue,

    // Memory side
    input  logic  almfull,
    output T      out_req
);

    // The head leaves when order control allows it and memory has room
    assign issue = head.valid && clear && !almfull;

    // Full reports the occupancy the register holds after the coming edge.
    // A requester sampling it at that edge then never overwrites a waiting head
    assign full = in_req.valid || (head.valid && !issue);

    // Memory sees the held payload with valid as a one-cycle strobe
    always_comb
    begin
        out_req = head;
        out_req.valid = issue;
    end

    // Load a new request, possibly in the same cycle the old one issues.
    // The hash is taken once here so later lookups see a stable value
    always_ff @(posedge clk)
    begin
        if (in_req.valid)
        begin
            head <= in_req;
            head_hash <= wro_hash(in_req.addr);
        end
        else if (issue)
        begin
            head.valid <= 1'b0;
        end

        if (reset)
        begin
            head.valid <= 1'b0;
        end
    end

endmodule

/* hdl/wro_busy_filter.sv */
// Counting filter over hash buckets; callers must not insert into a saturated bucket
`timescale 1ns/10ps

// ==================================================
// Saturating busy counters, one per hash value
// ==================================================

module wro_busy_filter
    import wro_pkg::*;
#(
    parameter int CNT_BITS = 4
)
(
    input  logic            clk,
    input  logic            reset,

    // Update ports, effective at the next edge
    input  logic            insert,
    input  t_hash           insert_hash,
    input  logic            remove,
    input  t_hash           remove_hash,

    // Two independent combinational lookups
    input  t_hash [1:0]     test_hash,
    output logic  [1:0]     test_busy,
    output logic  [1:0]     test_sat
);

    localparam int N_BUCKETS = 1 << HASH_BITS;

    logic [CNT_BITS-1:0] cnt [N_BUCKETS];

    // Busy when any entry is counted, saturated when one more would wrap
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            test_busy[i] = |cnt[test_hash[i]];
            test_sat[i] = &cnt[test_hash[i]];
        end
    end

    // Insert and remove on one bucket in one cycle cancel out
    always_ff @(posedge clk)
    begin
        if (insert && !(remove && (remove_hash == insert_hash)))
        begin
            cnt[insert_hash] <= cnt[insert_hash] + 1'b1;
        end
        if (remove && !(insert && (insert_hash == remove_hash)))
        begin
            cnt[remove_hash] <= cnt[remove_hash] - 1'b1;
        end

        if (reset)
        begin
            for (int i = 0; i < N_BUCKETS; i++)
            begin
                cnt[i] <= '0;
            end
        end
    end

endmodule

/* hdl/wro_order_ctrl.sv */
// Only ordered traffic is tracked; hash aliasing can block unrelated addresses
`timescale 1ns/10ps

module wro_order_ctrl
    import wro_pkg::*;
#(
    parameter int RD_CNT_BITS = 4,
    parameter int WR_CNT_BITS = 1
)
(
    input  logic        clk,
    input  logic        reset,
    input  t_rd_req     rd_head,
    input  t_hash       rd_hash,
    input  t_wr_req     wr_head,
    input  t_hash       wr_hash,
    input  logic        rd_issue,
    input  logic        wr_issue,
    input  t_heap_entry rd_remove,
    input  logic        rd_remove_en,
    input  t_heap_entry wr_remove,
    input  logic        wr_remove_en,
    output logic        rd_clear,
    output logic        wr_clear
);

    // Lookup slot 0 serves the read head, slot 1 the write head
    t_hash [1:0] heads_hash;
    logic  [1:0] rd_busy;
    logic  [1:0] rd_sat;
    logic  [1:0] wr_busy;
    logic        rd_head_match;

    assign heads_hash = {wr_hash, rd_hash};

    // ==================================================
    // Filters
    // ==================================================

    // Several ordered reads may share a bucket, up to the counter limit
    wro_busy_filter #(.CNT_BITS(RD_CNT_BITS)) i_rd_filter (
        .clk, .reset,
        .insert(rd_issue && rd_head.order), .insert_hash(rd_hash),
        .remove(rd_remove_en && rd_remove.order), .remove_hash(rd_remove.hash),
        .test_hash(heads_hash), .test_busy(rd_busy), .test_sat(rd_sat)
    );

    // A busy bucket already stops the next write, so it never saturates
    wro_busy_filter #(.CNT_BITS(WR_CNT_BITS)) i_wr_filter (
        .clk, .reset,
        .insert(wr_issue && wr_head.order), .insert_hash(wr_hash),
        .remove(wr_remove_en && wr_remove.order), .remove_hash(wr_remove.hash),
        .test_hash(heads_hash), .test_busy(wr_busy), .test_sat()
    );

    // ==================================================
    // Ordering rules
    // ==================================================

    // Write must not pass an ordered read heading to the same bucket this cycle
    assign rd_head_match = rd_head.valid && rd_head.order && (rd_hash == wr_hash);

    // Ordered read waits on writes and on a full read counter
    assign rd_clear = !rd_head.order || !(wr_busy[0] || rd_sat[0]);
    assign wr_clear = !wr_head.order || !(rd_busy[1] || wr_busy[1] || rd_head_match);

endmodule

/* hdl/wro_tag_heap.sv */
// Tag-indexed RAM; a tag must not be reissued before its response has returned
`timescale 1ns/10ps

module wro_tag_heap
    import wro_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Written when a request issues
    input  logic        wen,
    input  t_tag        waddr,
    input  t_heap_entry wdata,

    // Looked up with the incoming response
    input  logic        rsp_valid,
    input  t_tag        raddr,
    output t_heap_entry rdata,
    output t_rsp        rsp_out
);

    t_heap_entry mem [1 << TAG_BITS];

    // Response is delayed to line up with the registered read data
    always_ff @(posedge clk)
    begin
        if (wen)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];
        rsp_out.tag <= raddr;
        rsp_out.valid <= rsp_valid;
        if (reset)
            rsp_out.valid <= 1'b0;
    end

endmodule

/* hdl/wro_shim_top.sv */
// Write/read ordering shim; memory returns each tag once, no earlier than the cycle after issue
`timescale 1ns/10ps

module wro_shim_top
    import wro_pkg::*;
#(
    parameter int RD_CNT_BITS = 4,
    parameter int WR_CNT_BITS = 1
)
(
    input  logic    clk,
    input  logic    reset,
    input  t_rd_req afu_rd_req,
    input  t_wr_req afu_wr_req,
    output logic    afu_rd_full,
    output logic    afu_wr_full,
    output t_rd_req mem_rd_req,
    output t_wr_req mem_wr_req,
    input  logic    mem_rd_almfull,
    input  logic    mem_wr_almfull,
    input  t_rsp    mem_rd_rsp,
    input  t_rsp    mem_wr_rsp,
    output t_rsp    afu_rd_rsp,
    output t_rsp    afu_wr_rsp
);

    t_rd_req     rd_head;
    t_wr_req     wr_head;
    t_hash       rd_hash;
    t_hash       wr_hash;
    logic        rd_issue;
    logic        wr_issue;
    logic        rd_clear;
    logic        wr_clear;
    t_heap_entry rd_heap_wdata;
    t_heap_entry wr_heap_wdata;
    t_heap_entry rd_heap_rdata;
    t_heap_entry wr_heap_rdata;

    // ==================================================
    // Request side
    // ==================================================

    wro_req_stage #(.T(t_rd_req)) i_rd_stage (
        .clk, .reset, .in_req(afu_rd_req), .full(afu_rd_full),
        .clear(rd_clear), .head(rd_head), .head_hash(rd_hash), .issue(rd_issue),
        .almfull(mem_rd_almfull), .out_req(mem_rd_req)
    );

    wro_req_stage #(.T(t_wr_req)) i_wr_stage (
        .clk, .reset, .in_req(afu_wr_req), .full(afu_wr_full),
        .clear(wr_clear), .head(wr_head), .head_hash(wr_hash), .issue(wr_issue),
        .almfull(mem_wr_almfull), .out_req(mem_wr_req)
    );

    wro_order_ctrl #(.RD_CNT_BITS(RD_CNT_BITS), .WR_CNT_BITS(WR_CNT_BITS)) i_order_ctrl (
        .clk, .reset,
        .rd_head, .rd_hash, .wr_head, .wr_hash, .rd_issue, .wr_issue,
        .rd_remove(rd_heap_rdata), .rd_remove_en(afu_rd_rsp.valid),
        .wr_remove(wr_heap_rdata), .wr_remove_en(afu_wr_rsp.valid),
        .rd_clear, .wr_clear
    );

    // ==================================================
    // Response side
    // ==================================================

    // Heap entries remember what each issued tag put into the filters
    assign rd_heap_wdata.hash = rd_hash;
    assign rd_heap_wdata.order = rd_head.order;
    assign wr_heap_wdata.hash = wr_hash;
    assign wr_heap_wdata.order = wr_head.order;

    wro_tag_heap i_rd_heap (
        .clk, .reset, .wen(rd_issue), .waddr(rd_head.tag), .wdata(rd_heap_wdata),
        .rsp_valid(mem_rd_rsp.valid), .raddr(mem_rd_rsp.tag),
        .rdata(rd_heap_rdata), .rsp_out(afu_rd_rsp)
    );

    wro_tag_heap i_wr_heap (
        .clk, .reset, .wen(wr_issue), .waddr(wr_head.tag), .wdata(wr_heap_wdata),
        .rsp_valid(mem_wr_rsp.valid), .raddr(mem_wr_rsp.tag),
        .rdata(wr_heap_rdata), .rsp_out(afu_wr_rsp)
    );

endmodule

/* dv/wro_checker.sv */
// Samples everything at the falling edge; expects tags unique per channel while outstanding
`timescale 1ns/10ps

module wro_checker
    import wro_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  t_rd_req afu_rd_req,
    input  t_wr_req afu_wr_req,
    input  logic    afu_rd_full,
    input  logic    afu_wr_full,
    input  t_rd_req mem_rd_req,
    input  t_wr_req mem_wr_req,
    input  logic    mem_rd_almfull,
    input  logic    mem_wr_almfull,
    input  t_rsp    mem_rd_rsp,
    input  t_rsp    mem_wr_rsp,
    input  t_rsp    afu_rd_rsp,
    input  t_rsp    afu_wr_rsp,
    input  logic    end_check,
    output int      errs [6],
    output int      rd_done,
    output int      wr_done
);

    localparam int N_TAGS = 1 << TAG_BITS;

    // Accepted requests waiting to show up on the memory side
    t_rd_req rd_exp [$];
    t_wr_req wr_exp [$];
    t_rd_req exp_r;
    t_wr_req exp_w;

    // Outstanding state per tag, from issue until the afu response
    logic    rd_out [N_TAGS];
    t_hash   rd_h [N_TAGS];
    logic    rd_o [N_TAGS];
    logic    wr_out [N_TAGS];
    t_hash   wr_h [N_TAGS];
    logic    wr_o [N_TAGS];

    // Memory responses of the previous cycle, due on the afu side now
    t_rsp    rd_prev;
    t_rsp    wr_prev;
    t_hash   hr;
    t_hash   hw;
    int      bypass_seen;
    int      max_share;

    // Bucket rule: XOR of the three address slices, top slice padded with zeros
    function automatic t_hash bucket_of(input t_addr a);
        return a[5:0] ^ a[11:6] ^ {2'b00, a[15:12]};
    endfunction

    function automatic int rd_ordered_on(input t_hash h);
        int n;
        n = 0;
        for (int t = 0; t < N_TAGS; t++)
            if (rd_out[t] && rd_o[t] && rd_h[t] == h)
                n++;
        return n;
    endfunction

    function automatic int wr_ordered_on(input t_hash h);
        int n;
        n = 0;
        for (int t = 0; t < N_TAGS; t++)
            if (wr_out[t] && wr_o[t] && wr_h[t] == h)
                n++;
        return n;
    endfunction

    task automatic value_err(input int test, input string sig, input logic [63:0] exp,
                             input logic [63:0] got);
        errs[test]++;
        $display("ERR %s expected 0x%0h got 0x%0h at %0t", sig, exp, got, $time);
    endtask

    task automatic plain_err(input int test, input string msg);
        errs[test]++;
        $display("Check failed at %0t: %s", $time, msg);
    endtask

    always @(negedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 6; i++)
                errs[i] = 0;
            for (int t = 0; t < N_TAGS; t++)
            begin
                rd_out[t] = 1'b0;
                wr_out[t] = 1'b0;
            end
            rd_exp.delete();
            wr_exp.delete();
            rd_prev = '0;
            wr_prev = '0;
            rd_done = 0;
            wr_done = 0;
            bypass_seen = 0;
            max_share = 0;
        end
        else
        begin
            hr = bucket_of(mem_rd_req.addr);
            hw = bucket_of(mem_wr_req.addr);

            // ==================================================
            // Issue checks, against state from earlier cycles
            // ==================================================
            if (mem_rd_req.valid)
            begin
                if (mem_rd_almfull)
                    plain_err(5, "read issued while mem_rd_almfull was high");
                if (rd_exp.size() == 0)
                    plain_err(0, "read issued with no accepted request waiting");
                else
                begin
                    exp_r = rd_exp.pop_front();
                    if (mem_rd_req !== exp_r)
                        value_err(0, "mem_rd_req", 64'(exp_r), 64'(mem_rd_req));
                end
                if (mem_rd_req.order && wr_ordered_on(hr) > 0)
                    plain_err(1, "ordered read issued past an outstanding ordered write");
                if (!mem_rd_req.order && wr_ordered_on(hr) > 0)
                    bypass_seen++;
            end
            if (mem_wr_req.valid)
            begin
                if (mem_wr_almfull)
                    plain_err(5, "write issued while mem_wr_almfull was high");
                if (wr_exp.size() == 0)
                    plain_err(0, "write issued with no accepted request waiting");
                else
                begin
                    exp_w = wr_exp.pop_front();
                    if (mem_wr_req !== exp_w)
                        value_err(0, "mem_wr_req", 64'(exp_w), 64'(mem_wr_req));
                end
                if (mem_wr_req.order && (rd_ordered_on(hw) > 0 || wr_ordered_on(hw) > 0))
                    plain_err(2, "ordered write issued past an outstanding ordered access");
                if (!mem_wr_req.order && (rd_ordered_on(hw) > 0 || wr_ordered_on(hw) > 0))
                    bypass_seen++;
            end
            // An ordered write may not slip out beside an ordered read to its bucket
            if (mem_rd_req.valid && mem_wr_req.valid && mem_rd_req.order && mem_wr_req.order
                && hr == hw)
                plain_err(2, "ordered read and write to one hash issued in the same cycle");

            // ==================================================
            // Response pass-through and retirement
            // ==================================================
            if (afu_rd_rsp.valid !== rd_prev.valid
                || (rd_prev.valid && afu_rd_rsp.tag !== rd_prev.tag))
                value_err(4, "afu_rd_rsp", 64'(rd_prev), 64'(afu_rd_rsp));
            if (afu_wr_rsp.valid !== wr_prev.valid
                || (wr_prev.valid && afu_wr_rsp.tag !== wr_prev.tag))
                value_err(4, "afu_wr_rsp", 64'(wr_prev), 64'(afu_wr_rsp));
            if (afu_rd_rsp.valid)
            begin
                if (!rd_out[afu_rd_rsp.tag])
                    plain_err(4, "read response for a tag that was not outstanding");
                rd_out[afu_rd_rsp.tag] = 1'b0;
                rd_done++;
            end
            if (afu_wr_rsp.valid)
            begin
                if (!wr_out[afu_wr_rsp.tag])
                    plain_err(4, "write response for a tag that was not outstanding");
                wr_out[afu_wr_rsp.tag] = 1'b0;
                wr_done++;
            end
            rd_prev = mem_rd_rsp;
            wr_prev = mem_wr_rsp;

            // This cycle's issues count as outstanding from the next cycle on
            if (mem_rd_req.valid)
            begin
                rd_out[mem_rd_req.tag] = 1'b1;
                rd_h[mem_rd_req.tag] = hr;
                rd_o[mem_rd_req.tag] = mem_rd_req.order;
                if (mem_rd_req.order && rd_ordered_on(hr) > max_share)
                    max_share = rd_ordered_on(hr);
            end
            if (mem_wr_req.valid)
            begin
                wr_out[mem_wr_req.tag] = 1'b1;
                wr_h[mem_wr_req.tag] = hw;
                wr_o[mem_wr_req.tag] = mem_wr_req.order;
            end

            // Valid seen now is taken in at the coming rising edge
            if (afu_rd_req.valid)
                rd_exp.push_back(afu_rd_req);
            if (afu_wr_req.valid)
                wr_exp.push_back(afu_wr_req);

            // ==================================================
            // End of run
            // ==================================================
            if (end_check)
            begin
                for (int t = 0; t < N_TAGS; t++)
                    if (rd_out[t] || wr_out[t])
                        plain_err(4, $sformatf("tag 0x%0h was never returned", t));
                if (afu_rd_full || afu_wr_full)
                    plain_err(4, "a full output is still high at the end of the run");
                if (rd_exp.size() != 0 || wr_exp.size() != 0)
                    plain_err(0, "accepted requests never reached the memory side");
                if (bypass_seen == 0)
                    plain_err(3, "no unordered request ever passed a busy hash");
                if (max_share < 2)
                    plain_err(3, "ordered reads to one hash were never outstanding together");
            end
        end
    end

endmodule

/* dv/wro_tb.sv */
// Drives the shim from dv/wro_stimulus.txt, run from the project root; memory answers by tag delay
`timescale 1ns/10ps

module wro_tb
    import wro_pkg::*;
();

    localparam string STIM_FILE = "dv/wro_stimulus.txt";

    typedef struct packed {
        t_tag tag;
        int   due;
    } t_pend;

    logic    clk;
    logic    reset = 1'b1;
    t_rd_req afu_rd_req;
    t_wr_req afu_wr_req;
    logic    afu_rd_full;
    logic    afu_wr_full;
    t_rd_req mem_rd_req;
    t_wr_req mem_wr_req;
    logic    mem_rd_almfull = 1'b0;
    logic    mem_wr_almfull = 1'b0;
    t_rsp    mem_rd_rsp = '0;
    t_rsp    mem_wr_rsp = '0;
    t_rsp    afu_rd_rsp;
    t_rsp    afu_wr_rsp;
    logic    end_check = 1'b0;

    int      errs [6];
    int      rd_done;
    int      wr_done;
    string   test_names [6] = '{"payload integrity", "read-after-write order",
                                "write-after-read/write order", "unordered bypass, shared reads",
                                "response pass-through", "almost-full back-pressure"};

    // Stimulus split per channel, delays looked up by tag when memory answers
    t_rd_req rd_list [$];
    t_wr_req wr_list [$];
    int      rd_dly [1 << TAG_BITS];
    int      wr_dly [1 << TAG_BITS];
    t_pend   rd_pend [$];
    t_pend   wr_pend [$];
    int      n_lines = 0;
    bit      loaded = 1'b0;
    logic    rd_full_s = 1'b0;
    logic    wr_full_s = 1'b0;
    int      cyc = 0;
    logic [31:0] rng = 32'hdce9_5b75;

    wro_shim_top #(.RD_CNT_BITS(4), .WR_CNT_BITS(1)) i_dut (
        .clk, .reset, .afu_rd_req, .afu_wr_req, .afu_rd_full, .afu_wr_full,
        .mem_rd_req, .mem_wr_req, .mem_rd_almfull, .mem_wr_almfull,
        .mem_rd_rsp, .mem_wr_rsp, .afu_rd_rsp, .afu_wr_rsp
    );

    wro_checker i_chk (
        .clk, .reset, .afu_rd_req, .afu_wr_req, .afu_rd_full, .afu_wr_full,
        .mem_rd_req, .mem_wr_req, .mem_rd_almfull, .mem_wr_almfull,
        .mem_rd_rsp, .mem_wr_rsp, .afu_rd_rsp, .afu_wr_rsp,
        .end_check, .errs, .rd_done, .wr_done
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // Memory model
    // ==================================================

    // Falling edge: full levels for the requester, and what memory took in
    always @(negedge clk)
    begin
        rd_full_s = afu_rd_full;
        wr_full_s = afu_wr_full;
        if (!reset && mem_rd_req.valid)
            rd_pend.push_back(t_pend'{tag: mem_rd_req.tag, due: cyc + rd_dly[mem_rd_req.tag]});
        if (!reset && mem_wr_req.valid)
            wr_pend.push_back(t_pend'{tag: mem_wr_req.tag, due: cyc + wr_dly[mem_wr_req.tag]});
    end

    // One response per channel per cycle, the first one due in queue order
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        rng = xorshift(rng);
        mem_rd_almfull <= !reset && (rng[2:0] == 3'd0);
        mem_wr_almfull <= !reset && (rng[13:11] == 3'd0);
        mem_rd_rsp <= '0;
        mem_wr_rsp <= '0;
        for (int i = 0; i < rd_pend.size(); i++)
        begin
            if (rd_pend[i].due <= cyc + 1)
            begin
                mem_rd_rsp <= '{valid: 1'b1, tag: rd_pend[i].tag};
                rd_pend.delete(i);
                break;
            end
        end
        for (int i = 0; i < wr_pend.size(); i++)
        begin
            if (wr_pend[i].due <= cyc + 1)
            begin
                mem_wr_rsp <= '{valid: 1'b1, tag: wr_pend[i].tag};
                wr_pend.delete(i);
                break;
            end
        end
    end

    // ==================================================
    // Stimulus and result
    // ==================================================

    initial
    begin
        int      fd;
        int      chan;
        int      dly;
        int      ri;
        int      wi;
        int      total;
        int      failed;
        string   line;
        t_addr   addr;
        t_tag    tag;
        logic    ord;
        t_data   data;

        afu_rd_req = '0;
        afu_wr_req = '0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            $display("STATUS: FAIL");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                // Lines starting with a hash mark hold column notes
                if (line.len() > 1 && line.getc(0) != "#"
                    && $sscanf(line, "%d %h %h %d %h %d", chan, addr, tag, ord, data, dly) == 6)
                begin
                    if (chan == 0)
                    begin
                        rd_list.push_back('{valid: 1'b1, addr: addr, tag: tag, order: ord});
                        rd_dly[tag] = (dly < 1) ? 1 : dly;
                    end
                    else
                    begin
                        wr_list.push_back('{valid: 1'b1, addr: addr, tag: tag, order: ord,
                                            data: data});
                        wr_dly[tag] = (dly < 1) ? 1 : dly;
                    end
                end
            end
            $fclose(fd);
            n_lines = rd_list.size() + wr_list.size();
            loaded = 1'b1;

            repeat (3) @(posedge clk);
            reset <= 1'b0;

            // Present the next request only when full was low at this edge
            ri = 0;
            wi = 0;
            while (ri < rd_list.size() || wi < wr_list.size())
            begin
                @(posedge clk);
                if (!rd_full_s && ri < rd_list.size())
                begin
                    afu_rd_req <= rd_list[ri];
                    ri++;
                end
                else
                    afu_rd_req.valid <= 1'b0;
                if (!wr_full_s && wi < wr_list.size())
                begin
                    afu_wr_req <= wr_list[wi];
                    wi++;
                end
                else
                    afu_wr_req.valid <= 1'b0;
            end
            @(posedge clk);
            afu_rd_req.valid <= 1'b0;
            afu_wr_req.valid <= 1'b0;

            wait (rd_done == rd_list.size() && wr_done == wr_list.size());
            @(posedge clk);
            end_check <= 1'b1;
            @(posedge clk);
            end_check <= 1'b0;
            @(posedge clk);

            total = 0;
            failed = 0;
            for (int i = 0; i < 6; i++)
            begin
                $display("Test %0d %s: %s (%0d errors)", i + 1, test_names[i],
                         (errs[i] == 0) ? "passed" : "failed", errs[i]);
                total += errs[i];
                if (errs[i] != 0)
                    failed++;
            end
            $display("Tests %0d, passed %0d, failed %0d, errors %0d", 6, 6 - failed, failed,
                     total);
            if (total == 0)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

    // Watchdog sized from the stimulus length
    initial
    begin
        wait (loaded);
        repeat (200 * n_lines + 100) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the run finishing",
                 200 * n_lines + 100);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* wro_shim.f */
hdl/wro_pkg.sv
hdl/wro_req_stage.sv
hdl/wro_busy_filter.sv
hdl/wro_order_ctrl.sv
hdl/wro_tag_heap.sv
hdl/wro_shim_top.sv
dv/wro_checker.sv
dv/wro_tb.sv

/* Makefile */
# Verilator build and run of the ordering shim testbench

VERILATOR ?= verilator
TOP       ?= wro_tb
FILELIST  ?= wro_shim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench and scan the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/wro_stimulus.txt */
# chan (0 read, 1 write), addr hex, tag hex, order, data hex, response delay in cycles
# Tags are unique per channel over the whole file
1 0040 00 1 a5a5a5a5 30
0 0040 00 1 00000000 12
0 0040 01 1 00000000 20
1 0080 01 1 0badf00d 4
0 0040 02 1 00000000 20
1 0040 02 0 12345678 3
0 0080 03 0 00000000 2
1 0080 03 1 cafef00d 6
0 0000 04 1 00000000 3
1 1001 04 1 00c0ffee 5
0 0c80 05 1 00000000 4
1 0c80 05 1 5a5a5a5a 8
0 0040 06 1 00000000 5
1 0040 06 1 0f0f0f0f 2
0 2345 07 0 00000000 1
1 2345 07 1 deadbeef 3
0 0080 08 1 00000000 2
1 2345 08 1 feedface 9
0 0040 09 1 00000000 1
0 0c80 0a 1 00000000 7
